// File: verilog/periph_config.svh
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// ------------------------------
// Wishbone widths
// ------------------------------
`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32
`define PERIPH_SEL_W 4

// ------------------------------
// Address map, region field is adr[11:8]
// ------------------------------
`define PERIPH_REGION_TIMER 4'd0
`define PERIPH_REGION_IRQ 4'd1

// Interrupt sources, source 0 is the timer
`define PERIPH_EXT_IRQS 7
`define PERIPH_NUM_SOURCES 8
`define PERIPH_SOURCE_ID_W 4

// Read data returned with an error response
`define PERIPH_ERR_RDATA 32'hDEADBEEF

`endif

// File: verilog/periph_pkg.sv
`include "periph_config.svh"

package periph_pkg;

    // ------------------------------
    // Wishbone classic channels
    // ------------------------------
    typedef struct packed {
        logic                        cyc;
        logic                        stb;
        logic                        we;
        logic [`PERIPH_ADDR_W-1:0]   adr;
        logic [`PERIPH_DATA_W-1:0]   dat;
        logic [`PERIPH_SEL_W-1:0]    sel;
    } wb_req_t;

    typedef struct packed {
        logic                        ack;
        logic                        err;
        logic [`PERIPH_DATA_W-1:0]   dat;
    } wb_rsp_t;

    // ------------------------------
    // Address layout
    // ------------------------------
    typedef struct packed {
        logic [19:0] unused;
        logic [3:0]  region;
        logic [5:0]  index;
        logic [1:0]  offset;
    } periph_addr_fields_t;

    // Same word seen raw or split into fields
    typedef union packed {
        logic [`PERIPH_ADDR_W-1:0] raw;
        periph_addr_fields_t       fields;
    } periph_addr_u;

endpackage

// File: verilog/periph_bus_decoder.sv
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_bus_decoder import periph_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o,
    output wb_req_t timer_req_o,
    input  wb_rsp_t timer_rsp_i,
    output wb_req_t irq_req_o,
    input  wb_rsp_t irq_rsp_i
);

    periph_addr_u addr;
    logic         aligned;
    logic         hit_timer;
    logic         hit_irq;
    logic         err_q;

    assign addr.raw = wb_req_i.adr;

    // ------------------------------
    // Region decode
    // ------------------------------
    // Upper bits and byte offset must be clear for a mapped access
    assign aligned   = (addr.fields.unused == '0) && (addr.fields.offset == '0);
    assign hit_timer = aligned && (addr.fields.region == `PERIPH_REGION_TIMER);
    assign hit_irq   = aligned && (addr.fields.region == `PERIPH_REGION_IRQ);

    // Slaves see the full request, only stb is steered
    always_comb begin
        timer_req_o     = wb_req_i;
        timer_req_o.stb = wb_req_i.stb && hit_timer;
        irq_req_o       = wb_req_i;
        irq_req_o.stb   = wb_req_i.stb && hit_irq;
    end

    // ------------------------------
    // Error responder
    // ------------------------------
    // One err pulse per held strobe, same latency as the slaves
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= wb_req_i.cyc && wb_req_i.stb && !hit_timer && !hit_irq && !err_q;
        end
    end

    // ------------------------------
    // Response merge
    // ------------------------------
    // Idle slaves drive zero data, so a plain OR is enough
    always_comb begin
        wb_rsp_o.ack = timer_rsp_i.ack | irq_rsp_i.ack;
        wb_rsp_o.err = timer_rsp_i.err | irq_rsp_i.err | err_q;
        wb_rsp_o.dat = timer_rsp_i.dat | irq_rsp_i.dat;
        if (err_q) begin
            wb_rsp_o.dat = wb_rsp_o.dat | `PERIPH_ERR_RDATA;
        end
    end

    // Exactly one kind of answer per access, across all targets
    a_ack_err_excl: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(wb_rsp_o.ack && wb_rsp_o.err)
    ) else $error("ack and err high together");

    // At most one slave selected
    a_one_slave: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(timer_req_o.stb && irq_req_o.stb)
    ) else $error("both slave strobes high");

endmodule

// File: verilog/periph_timer.sv
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_timer import periph_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o,
    output logic    irq_o
);

    localparam int         DW          = `PERIPH_DATA_W;
    localparam logic [5:0] IDX_CTRL    = 6'd0;
    localparam logic [5:0] IDX_COUNT   = 6'd1;
    localparam logic [5:0] IDX_COMPARE = 6'd2;
    localparam logic [5:0] IDX_STATUS  = 6'd3;

    periph_addr_fields_t addr_f;
    logic                access;
    logic                wr_en;
    logic                match;
    logic                ack_q;
    logic [DW-1:0]       rdata_d;
    logic [DW-1:0]       rdata_q;
    logic                enable_q;
    logic                pending_q;
    logic [DW-1:0]       count_q;
    logic [DW-1:0]       compare_q;

    // Merge write data into a register under the byte selects
    function automatic logic [DW-1:0] apply_sel(
        input logic [DW-1:0]            old_val,
        input logic [DW-1:0]            new_val,
        input logic [`PERIPH_SEL_W-1:0] sel
    );
        logic [DW-1:0] res;
        res = old_val;
        for (int b = 0; b < `PERIPH_SEL_W; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign addr_f = wb_req_i.adr;
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en  = access && wb_req_i.we;
    assign match  = enable_q && (count_q == compare_q);

    // ------------------------------
    // Counter and registers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable_q  <= 1'b0;
            pending_q <= 1'b0;
            count_q   <= '0;
            compare_q <= '0;
        end else begin
            // Wrap on compare and flag it
            if (match) begin
                count_q   <= '0;
                pending_q <= 1'b1;
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end
            if (wr_en) begin
                case (addr_f.index)
                    IDX_CTRL: if (wb_req_i.sel[0]) enable_q <= wb_req_i.dat[0];
                    IDX_COUNT: count_q <= apply_sel(count_q, wb_req_i.dat, wb_req_i.sel);
                    IDX_COMPARE: compare_q <= apply_sel(compare_q, wb_req_i.dat, wb_req_i.sel);
                    // Write one to clear, a new match wins
                    IDX_STATUS: if (wb_req_i.sel[0] && wb_req_i.dat[0] && !match) begin
                        pending_q <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (addr_f.index)
            IDX_CTRL:    rdata_d = {{(DW-1){1'b0}}, enable_q};
            IDX_COUNT:   rdata_d = count_q;
            IDX_COMPARE: rdata_d = compare_q;
            IDX_STATUS:  rdata_d = {{(DW-1){1'b0}}, pending_q};
            default:     rdata_d = '0;
        endcase
    end

    // ------------------------------
    // Bus response
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            rdata_q <= rdata_d;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.err = 1'b0;
    assign wb_rsp_o.dat = ack_q ? rdata_q : '0;
    assign irq_o        = pending_q;

    // Strobe here is already region-gated by the decoder
    a_ack_after_stb: assert property (
        @(posedge clk_i) disable iff (reset_i)
        wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb)
    ) else $error("timer ack without preceding strobe");

endmodule

// File: verilog/periph_irq_ctrl.sv
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_irq_ctrl import periph_pkg::*; (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  wb_req_t                        wb_req_i,
    output wb_rsp_t                        wb_rsp_o,
    input  logic [`PERIPH_NUM_SOURCES-1:0] sources_i,
    output logic                           irq_o
);

    localparam int         NUM_SRC     = `PERIPH_NUM_SOURCES;
    localparam int         ID_W        = `PERIPH_SOURCE_ID_W;
    localparam logic [5:0] IDX_PENDING = 6'd0;
    localparam logic [5:0] IDX_ENABLE  = 6'd1;
    localparam logic [5:0] IDX_CLAIM   = 6'd2;

    periph_addr_fields_t       addr_f;
    logic                      access;
    logic                      wr_en;
    logic                      ack_q;
    logic                      irq_q;
    logic [NUM_SRC-1:0]        enable_q;
    logic [NUM_SRC-1:0]        active;
    logic [ID_W-1:0]           claim_id;
    logic [`PERIPH_DATA_W-1:0] rdata_d;
    logic [`PERIPH_DATA_W-1:0] rdata_q;

    assign addr_f = wb_req_i.adr;
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en  = access && wb_req_i.we && (addr_f.index == IDX_ENABLE);

    // ------------------------------
    // Source gating and claim
    // ------------------------------
    assign active = sources_i & enable_q;

    // Lowest numbered active source wins, ID is source plus one
    always_comb begin
        claim_id = '0;
        for (int s = NUM_SRC - 1; s >= 0; s--) begin
            if (active[s]) begin
                claim_id = ID_W'(s + 1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable_q <= '0;
            irq_q    <= 1'b0;
        end else begin
            irq_q <= |active;
            if (wr_en) begin
                for (int b = 0; b < NUM_SRC; b++) begin
                    if (wb_req_i.sel[b / 8]) begin
                        enable_q[b] <= wb_req_i.dat[b];
                    end
                end
            end
        end
    end

    // ------------------------------
    // Bus response
    // ------------------------------
    always_comb begin
        rdata_d = '0;
        case (addr_f.index)
            IDX_PENDING: rdata_d[NUM_SRC-1:0] = sources_i;
            IDX_ENABLE:  rdata_d[NUM_SRC-1:0] = enable_q;
            IDX_CLAIM:   rdata_d[ID_W-1:0]    = claim_id;
            default:     rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            rdata_q <= rdata_d;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.err = 1'b0;
    assign wb_rsp_o.dat = ack_q ? rdata_q : '0;
    assign irq_o        = irq_q;

    // Interrupt only ever follows an enabled, pending source
    a_irq_cause: assert property (
        @(posedge clk_i) disable iff (reset_i)
        irq_o |-> $past(|(sources_i & enable_q))
    ) else $error("irq_o high without an enabled source");

endmodule

// File: verilog/periph_subsystem.sv
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_subsystem import periph_pkg::*; (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  wb_req_t                     wb_req_i,
    output wb_rsp_t                     wb_rsp_o,
    input  logic [`PERIPH_EXT_IRQS-1:0] ext_irq_i,
    output logic                        irq_o
);

    wb_req_t timer_req;
    wb_rsp_t timer_rsp;
    wb_req_t irq_req;
    wb_rsp_t irq_rsp;
    logic    timer_irq;

    periph_bus_decoder u_decoder (
        .clk_i       ( clk_i     ),
        .reset_i     ( reset_i   ),
        .wb_req_i    ( wb_req_i  ),
        .wb_rsp_o    ( wb_rsp_o  ),
        .timer_req_o ( timer_req ),
        .timer_rsp_i ( timer_rsp ),
        .irq_req_o   ( irq_req   ),
        .irq_rsp_i   ( irq_rsp   )
    );

    periph_timer u_timer (
        .clk_i    ( clk_i     ),
        .reset_i  ( reset_i   ),
        .wb_req_i ( timer_req ),
        .wb_rsp_o ( timer_rsp ),
        .irq_o    ( timer_irq )
    );

    // Timer is source 0, external lines follow
    periph_irq_ctrl u_irq_ctrl (
        .clk_i     ( clk_i                  ),
        .reset_i   ( reset_i                ),
        .wb_req_i  ( irq_req                ),
        .wb_rsp_o  ( irq_rsp                ),
        .sources_i ( {ext_irq_i, timer_irq} ),
        .irq_o     ( irq_o                  )
    );

endmodule

// File: tests/tb_periph_subsystem.sv
`timescale 1ns/1ps
`include "periph_config.svh"

module tb_periph_subsystem import periph_pkg::*; ();

    localparam int          TIMEOUT    = 200;
    localparam logic [31:0] TIMER_BASE = 32'h0000_0000;
    localparam logic [31:0] IRQ_BASE   = 32'h0000_0100;
    // Register word indexes
    localparam int T_CTRL    = 0;
    localparam int T_COMPARE = 2;
    localparam int T_STATUS  = 3;
    localparam int I_PENDING = 0;
    localparam int I_ENABLE  = 1;
    localparam int I_CLAIM   = 2;

    logic                        clk;
    logic                        reset;
    logic                        irq;
    logic [`PERIPH_EXT_IRQS-1:0] ext_irq;
    wb_req_t                     wb_req;
    wb_rsp_t                     wb_rsp;
    int                          errors;
    int                          seed;
    int                          line_a;
    int                          line_b;
    int                          lo;
    int                          hi;
    logic [31:0]                 value;
    logic [31:0]                 rsp_dat;
    logic                        rsp_ack;
    logic                        rsp_err;

    periph_subsystem dut0 (
        .clk_i     ( clk     ),
        .reset_i   ( reset   ),
        .wb_req_i  ( wb_req  ),
        .wb_rsp_o  ( wb_rsp  ),
        .ext_irq_i ( ext_irq ),
        .irq_o     ( irq     )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // Bus protocol checks
    // ------------------------------
    a_rsp_latency: assert property (@(posedge clk) disable iff (reset)
        $rose(wb_req.cyc && wb_req.stb) |=> (wb_rsp.ack || wb_rsp.err)
    ) else begin
        errors++;
        $display("No response one cycle after the strobe at %0t", $time);
    end

    a_rsp_cause: assert property (@(posedge clk) disable iff (reset)
        (wb_rsp.ack || wb_rsp.err) |-> $past(wb_req.cyc && wb_req.stb)
    ) else begin
        errors++;
        $display("Response without a strobe in the cycle before at %0t", $time);
    end

    a_ack_err_excl: assert property (@(posedge clk) disable iff (reset)
        !(wb_rsp.ack && wb_rsp.err)
    ) else begin
        errors++;
        $display("ack and err high together at %0t", $time);
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] reg_addr(input logic [31:0] base, input int idx);
        return base + 32'(idx * 4);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        a_value: assert (actual === expected) else begin
            errors++;
            $display("** Error: %s expected %h, got %h", name, expected, actual);
        end
    endtask

    // One classic cycle, response sampled 1 ns after the edge
    task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat);
        int waited;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wb_req.sel = 4'hF;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!(wb_rsp.ack || wb_rsp.err) && waited < TIMEOUT);
        rsp_ack = wb_rsp.ack;
        rsp_err = wb_rsp.err;
        rsp_dat = wb_rsp.dat;
        if (!(rsp_ack || rsp_err)) begin
            errors++;
            $display("Timeout waiting for a Wishbone response at address %h", adr);
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
        wb_access(1'b1, adr, dat);
        check_value("wb_rsp_o.ack", 32'd1, 32'(rsp_ack));
        check_value("wb_rsp_o.err", 32'd0, 32'(rsp_err));
    endtask

    task automatic wb_read(input string name, input logic [31:0] adr,
                           input logic [31:0] expected);
        wb_access(1'b0, adr, 32'd0);
        check_value("wb_rsp_o.ack", 32'd1, 32'(rsp_ack));
        check_value("wb_rsp_o.err", 32'd0, 32'(rsp_err));
        check_value(name, expected, rsp_dat);
    endtask

    // Both a write and a read must hit the error responder
    task automatic expect_error(input logic [31:0] adr);
        for (int we = 0; we < 2; we++) begin
            wb_access(we[0], adr, $random(seed));
            check_value("wb_rsp_o.err", 32'd1, 32'(rsp_err));
            check_value("wb_rsp_o.ack", 32'd0, 32'(rsp_ack));
            check_value("wb_rsp_o.dat", `PERIPH_ERR_RDATA, rsp_dat);
        end
    endtask

    task automatic wait_irq(input logic level);
        int waited;
        waited = 0;
        while (irq !== level && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (irq !== level) begin
            errors++;
            $display("Timeout waiting for irq_o to become %0d", level);
        end
    endtask

    task automatic check_irq_stays_low(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check_value("irq_o", 32'd0, 32'(irq));
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        errors  = 0;
        seed    = 63;
        reset   = 1'b1;
        wb_req  = '0;
        ext_irq = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("wb_rsp_o.ack", 32'd0, 32'(wb_rsp.ack));
        check_value("wb_rsp_o.err", 32'd0, 32'(wb_rsp.err));
        check_value("irq_o", 32'd0, 32'(irq));

        // Read back, only 8 enable bits exist
        for (int i = 0; i < 4; i++) begin
            value = $random(seed);
            wb_write(reg_addr(TIMER_BASE, T_COMPARE), value);
            wb_read("timer COMPARE", reg_addr(TIMER_BASE, T_COMPARE), value);
            value = $random(seed);
            wb_write(reg_addr(IRQ_BASE, I_ENABLE), value);
            wb_read("irq ENABLE", reg_addr(IRQ_BASE, I_ENABLE), value & 32'hFF);
        end

        // Unmapped region, misaligned timer word, upper bits set
        expect_error(32'h0000_0500);
        expect_error(32'h0000_0009);
        expect_error(32'h0010_0004);

        // Timer match raises source 0
        value = ($random(seed) & 32'h1F) + 32'd8;
        wb_write(reg_addr(TIMER_BASE, T_COMPARE), value);
        wb_write(reg_addr(IRQ_BASE, I_ENABLE), 32'h1);
        wb_write(reg_addr(TIMER_BASE, T_CTRL), 32'h1);
        wait_irq(1'b1);
        wb_read("timer STATUS", reg_addr(TIMER_BASE, T_STATUS), 32'h1);
        wb_read("irq CLAIM", reg_addr(IRQ_BASE, I_CLAIM), 32'h1);
        wb_write(reg_addr(TIMER_BASE, T_CTRL), 32'h0);
        wb_write(reg_addr(TIMER_BASE, T_STATUS), 32'h1);
        wait_irq(1'b0);

        // Two distinct external lines, source number is line plus one
        line_a = $unsigned($random(seed)) % `PERIPH_EXT_IRQS;
        line_b = (line_a + 1 + $unsigned($random(seed)) % (`PERIPH_EXT_IRQS - 1))
                 % `PERIPH_EXT_IRQS;
        lo = (line_a < line_b) ? line_a : line_b;
        hi = (line_a < line_b) ? line_b : line_a;
        ext_irq[lo] = 1'b1;
        ext_irq[hi] = 1'b1;
        wb_write(reg_addr(IRQ_BASE, I_ENABLE), 32'd1 << (hi + 1));
        wait_irq(1'b1);
        wb_read("irq CLAIM", reg_addr(IRQ_BASE, I_CLAIM), 32'(hi + 2));
        wb_write(reg_addr(IRQ_BASE, I_ENABLE), (32'd1 << (hi + 1)) | (32'd1 << (lo + 1)));
        wb_read("irq CLAIM", reg_addr(IRQ_BASE, I_CLAIM), 32'(lo + 2));
        wb_write(reg_addr(IRQ_BASE, I_ENABLE), 32'h0);
        wait_irq(1'b0);
        check_irq_stays_low(8);
        wb_read("irq PENDING", reg_addr(IRQ_BASE, I_PENDING), {24'd0, ext_irq, 1'b0});
        check_value("irq_o", 32'd0, 32'(irq));
        ext_irq = '0;

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verilog
verilog/periph_pkg.sv
verilog/periph_bus_decoder.sv
verilog/periph_timer.sv
verilog/periph_irq_ctrl.sv
verilog/periph_subsystem.sv
tests/tb_periph_subsystem.sv

// File: Makefile
TOP := tb_periph_subsystem
SRCS := filelist.f $(wildcard verilog/*.sv verilog/*.svh tests/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

# Pass only if the pass line shows up in the simulator output
sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
